//--- run_sim.sh
#!/bin/sh
# Build the VLIW core testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
   -f src.f --top-module vliw_tb -Mdir "$BUILD_DIR" -o vliw_sim

# A failing run exits non-zero, the log decides the result
"$BUILD_DIR"/vliw_sim > "$LOG_FILE" 2>&1 || true
cat "$LOG_FILE"

if grep -qx "All tests passed" "$LOG_FILE"; then
   echo "Simulation PASSED"
   exit 0
else
   echo "Simulation FAILED"
   exit 1
fi

//--- sim/vliw_tb.sv
//====================
// VLIW core testbench
// Drives the four slots and checks z against a reference model
//====================
`timescale 1ns/1ps
`include "vliw_params.svh"

module vliw_tb;
   import vliw_pkg::*;

   localparam int CLK_PERIOD_NS = 4;
   localparam int RESET_CYCLES  = 4;
   // Upper bound on cycles driven by all tests plus pipeline slack
   localparam int TEST_CYCLES   = 48;
   localparam int MARGIN_CYCLES = 32;
   localparam int WATCHDOG_NS   = (RESET_CYCLES + TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD_NS;

   logic        clk;
   logic        reset;
   load_slot_t  load_slot;
   neg_slot_t   neg_slot;
   arith_slot_t add_slot;
   arith_slot_t mul_slot;
   data_t       z_re;
   data_t       z_im;

   integer      seed = 62822;
   string       test_name = "reset";

   //====================
   // Reference model state
   //====================
   data_t       m_bank [`VLIW_NUM_UNITS][`VLIW_NUM_ENTRIES];
   data_t       m_z_re;
   data_t       m_z_im;
   logic        m_add_valid;
   entry_t      m_add_entry;
   data_t       m_add_sum;

   // Per-unit write requests of the current edge
   logic        req_valid [`VLIW_NUM_UNITS];
   entry_t      req_entry [`VLIW_NUM_UNITS];
   data_t       req_data  [`VLIW_NUM_UNITS];
   data_t       z_re_next;
   data_t       z_im_next;
   logic        re_taken;
   logic        im_taken;

   vliw_core vliw_core_inst (
      .clk       (clk),
      .reset     (reset),
      .load_slot (load_slot),
      .neg_slot  (neg_slot),
      .add_slot  (add_slot),
      .mul_slot  (mul_slot),
      .z_re      (z_re),
      .z_im      (z_im)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD_NS / 2) clk = ~clk;
   end

   // Arithmetic of each unit on 27-bit two's-complement words
   function automatic data_t unit_result(input unit_e u, input data_t a, input data_t b,
                                         input data_t value);
      logic [2*`VLIW_DATA_W-1:0] prod;
      data_t                     result;
      prod = {{`VLIW_DATA_W{1'b0}}, a} * {{`VLIW_DATA_W{1'b0}}, b};
      case (u)
         unit_load: result = value;
         unit_neg:  result = ~a + data_t'(1);
         unit_add:  result = a + b;
         default:   result = prod[`VLIW_DATA_W-1:0];
      endcase
      return result;
   endfunction

   function automatic data_t read_operand(input reg_addr_t a);
      data_t d;
      if (a.entry == entry_t'(`VLIW_Z_RE_ENTRY)) begin
         d = m_z_re;
      end else if (a.entry == entry_t'(`VLIW_Z_IM_ENTRY)) begin
         d = m_z_im;
      end else begin
         d = m_bank[a.unit][a.entry];
      end
      return d;
   endfunction

   always @(posedge clk) begin
      if (reset) begin
         for (int u = 0; u < `VLIW_NUM_UNITS; u++) begin
            for (int e = 0; e < `VLIW_NUM_ENTRIES; e++) begin
               m_bank[u][e] <= '0;
            end
         end
         m_z_re      <= '0;
         m_z_im      <= '0;
         m_add_valid <= 1'b0;
      end else begin
         req_valid[unit_load] = load_slot.enable;
         req_entry[unit_load] = load_slot.dest.entry;
         req_data[unit_load]  = unit_result(unit_load, '0, '0, load_slot.value);
         req_valid[unit_neg]  = neg_slot.enable;
         req_entry[unit_neg]  = neg_slot.dest.entry;
         req_data[unit_neg]   = unit_result(unit_neg, read_operand(neg_slot.src), '0, '0);
         // Sum issued on the previous edge lands now
         req_valid[unit_add]  = m_add_valid;
         req_entry[unit_add]  = m_add_entry;
         req_data[unit_add]   = m_add_sum;
         req_valid[unit_mul]  = mul_slot.enable;
         req_entry[unit_mul]  = mul_slot.dest.entry;
         req_data[unit_mul]   = unit_result(unit_mul, read_operand(mul_slot.src1),
                                            read_operand(mul_slot.src2), '0);

         // First valid writer in load, negate, add, multiply order takes z
         z_re_next = m_z_re;
         z_im_next = m_z_im;
         re_taken  = 1'b0;
         im_taken  = 1'b0;
         for (int u = 0; u < `VLIW_NUM_UNITS; u++) begin
            if (req_valid[u] && !re_taken && req_entry[u] == entry_t'(`VLIW_Z_RE_ENTRY)) begin
               z_re_next = req_data[u];
               re_taken  = 1'b1;
            end
            if (req_valid[u] && !im_taken && req_entry[u] == entry_t'(`VLIW_Z_IM_ENTRY)) begin
               z_im_next = req_data[u];
               im_taken  = 1'b1;
            end
            if (req_valid[u]) begin
               m_bank[u][req_entry[u]] <= req_data[u];
            end
         end
         m_z_re      <= z_re_next;
         m_z_im      <= z_im_next;
         m_add_valid <= add_slot.enable;
         m_add_entry <= add_slot.dest.entry;
         m_add_sum   <= unit_result(unit_add, read_operand(add_slot.src1),
                                    read_operand(add_slot.src2), '0);
      end
   end

   task automatic check_value(input string what, input data_t expected, input data_t actual);
      if (expected !== actual) begin
         $display("error %s %s: expected %h actual %h", test_name, what, expected, actual);
         $display("Some tests failed");
         $fatal(1, "stopping at first mismatch");
      end
   endtask

   // Registered outputs are settled mid-cycle
   initial begin
      forever begin
         @(negedge clk);
         if (!reset) begin
            check_value("z_re", m_z_re, z_re);
            check_value("z_im", m_z_im, z_im);
         end
      end
   end

   initial begin
      #(WATCHDOG_NS);
      $display("watchdog expired before the tests finished");
      $display("Some tests failed");
      $fatal(1, "timeout");
   end

   //====================
   // Stimulus helpers
   //====================
   function automatic reg_addr_t addr_of(input unit_e u, input int e);
      reg_addr_t a;
      a.unit  = u;
      a.entry = entry_t'(e);
      return a;
   endfunction

   function automatic reg_addr_t z_addr(input bit im);
      return addr_of(unit_load, im ? `VLIW_Z_IM_ENTRY : `VLIW_Z_RE_ENTRY);
   endfunction

   task automatic load_entry(input reg_addr_t dest, input data_t value);
      load_slot.enable = 1'b1;
      load_slot.dest   = dest;
      load_slot.value  = value;
   endtask

   task automatic negate_to(input reg_addr_t src, input reg_addr_t dest);
      neg_slot.enable = 1'b1;
      neg_slot.src    = src;
      neg_slot.dest   = dest;
   endtask

   task automatic add_to(input reg_addr_t a, input reg_addr_t b, input reg_addr_t dest);
      add_slot.enable = 1'b1;
      add_slot.src1   = a;
      add_slot.src2   = b;
      add_slot.dest   = dest;
   endtask

   task automatic multiply_to(input reg_addr_t a, input reg_addr_t b, input reg_addr_t dest);
      mul_slot.enable = 1'b1;
      mul_slot.src1   = a;
      mul_slot.src2   = b;
      mul_slot.dest   = dest;
   endtask

   // Hold the slots for one edge and go idle 1 ns after it
   task automatic advance();
      @(posedge clk);
      #1;
      load_slot = '0;
      neg_slot  = '0;
      add_slot  = '0;
      mul_slot  = '0;
   endtask

   //====================
   // Tests
   //====================
   initial begin
      reset     = 1'b1;
      load_slot = '0;
      neg_slot  = '0;
      add_slot  = '0;
      mul_slot  = '0;
      repeat (RESET_CYCLES) @(posedge clk);
      #1;
      reset = 1'b0;

      test_name = "z_load";
      load_entry(z_addr(0), data_t'($random(seed)));
      advance();
      load_entry(z_addr(1), data_t'($random(seed)));
      advance();

      test_name = "negate";
      for (int e = 2; e < 8; e++) begin
         load_entry(addr_of(unit_load, e), data_t'($random(seed)));
         advance();
      end
      negate_to(addr_of(unit_load, 2), z_addr(0));
      advance();
      negate_to(addr_of(unit_load, 3), z_addr(1));
      advance();
      // Most negative word wraps onto itself
      load_entry(addr_of(unit_load, 8), {1'b1, {(`VLIW_DATA_W-1){1'b0}}});
      advance();
      negate_to(addr_of(unit_load, 8), z_addr(0));
      advance();

      test_name = "multiply";
      multiply_to(addr_of(unit_load, 2), addr_of(unit_load, 3), z_addr(0));
      advance();
      multiply_to(addr_of(unit_load, 4), addr_of(unit_load, 5), z_addr(1));
      advance();
      multiply_to(z_addr(0), z_addr(1), z_addr(0));
      advance();

      test_name = "add_pipeline";
      add_to(addr_of(unit_load, 2), addr_of(unit_load, 3), z_addr(0));
      advance();
      add_to(addr_of(unit_load, 4), addr_of(unit_load, 5), z_addr(1));
      advance();
      add_to(z_addr(0), z_addr(1), z_addr(0));
      advance();
      repeat (2) advance();

      test_name = "bank_forward";
      negate_to(addr_of(unit_load, 7), addr_of(unit_neg, 5));
      advance();
      multiply_to(addr_of(unit_neg, 5), addr_of(unit_load, 4), z_addr(1));
      advance();
      add_to(addr_of(unit_load, 2), addr_of(unit_load, 6), addr_of(unit_add, 9));
      repeat (2) advance();
      negate_to(addr_of(unit_add, 9), z_addr(0));
      advance();

      test_name = "z_priority";
      add_to(addr_of(unit_load, 2), addr_of(unit_load, 3), z_addr(0));
      advance();
      load_entry(z_addr(0), data_t'($random(seed)));
      negate_to(addr_of(unit_load, 4), z_addr(0));
      multiply_to(addr_of(unit_load, 5), addr_of(unit_load, 6), z_addr(0));
      add_to(addr_of(unit_load, 3), addr_of(unit_load, 7), z_addr(0));
      advance();
      negate_to(addr_of(unit_load, 5), z_addr(0));
      multiply_to(addr_of(unit_load, 2), addr_of(unit_load, 4), z_addr(0));
      add_to(addr_of(unit_load, 6), addr_of(unit_load, 7), z_addr(0));
      advance();
      multiply_to(addr_of(unit_load, 3), addr_of(unit_load, 5), z_addr(0));
      advance();
      multiply_to(addr_of(unit_load, 4), addr_of(unit_load, 7), z_addr(0));
      load_entry(z_addr(1), data_t'($random(seed)));
      advance();
      multiply_to(addr_of(unit_load, 6), addr_of(unit_load, 7), z_addr(1));
      advance();
      repeat (3) advance();

      $display("All tests passed");
      $finish;
   end

endmodule

//--- source/exec_units.sv
//====================
// Execution units
// Negate, multiply and a one-stage adder, one write request per unit
//====================
`timescale 1ns/1ps
`include "vliw_params.svh"

module exec_units (
   input  logic                  clk,
   input  logic                  reset,
   input  vliw_pkg::load_slot_t  load_slot,
   input  vliw_pkg::neg_slot_t   neg_slot,
   input  vliw_pkg::arith_slot_t add_slot,
   input  vliw_pkg::arith_slot_t mul_slot,
   input  vliw_pkg::data_t       operand [`VLIW_NUM_RD_PORTS],
   output vliw_pkg::wr_req_t     wr_req  [`VLIW_NUM_UNITS]
);
   import vliw_pkg::*;

   data_t                      neg_result;
   logic [2*`VLIW_DATA_W-1:0]  mul_full;
   data_t                      mul_result;

   // Add pipeline stage
   logic                       add_valid;
   entry_t                     add_entry;
   data_t                      add_sum;

   // Wrapping two's-complement negate
   assign neg_result = -operand[port_neg];

   // Only the low word of the product is kept
   assign mul_full   = operand[port_mul1] * operand[port_mul2];
   assign mul_result = mul_full[`VLIW_DATA_W-1:0];

   always_ff @(posedge clk) begin
      if (reset) begin
         add_valid <= 1'b0;
      end else begin
         add_valid <= add_slot.enable;
      end
   end

   always_ff @(posedge clk) begin
      add_entry <= add_slot.dest.entry;
      add_sum   <= operand[port_add1] + operand[port_add2];
   end

   //====================
   // Write requests
   //====================
   always_comb begin
      wr_req[unit_load].valid = load_slot.enable;
      wr_req[unit_load].entry = load_slot.dest.entry;
      wr_req[unit_load].data  = load_slot.value;

      wr_req[unit_neg].valid  = neg_slot.enable;
      wr_req[unit_neg].entry  = neg_slot.dest.entry;
      wr_req[unit_neg].data   = neg_result;

      // Adder writes one cycle after issue
      wr_req[unit_add].valid  = add_valid;
      wr_req[unit_add].entry  = add_entry;
      wr_req[unit_add].data   = add_sum;

      wr_req[unit_mul].valid  = mul_slot.enable;
      wr_req[unit_mul].entry  = mul_slot.dest.entry;
      wr_req[unit_mul].data   = mul_result;
   end

   // Pipeline valid must stay defined once out of reset
   a_add_valid_known: assert property (
      @(posedge clk) disable iff (reset)
      !$isunknown(add_valid)
   ) else $error("add pipeline valid is unknown");

endmodule

//--- source/operand_router.sv
//====================
// Operand router
// Picks each source operand from z or from the named unit's bank
//====================
`timescale 1ns/1ps
`include "vliw_params.svh"

module operand_router (
   input  vliw_pkg::reg_addr_t src_addr  [`VLIW_NUM_RD_PORTS],
   input  vliw_pkg::rd_data_t  bank_data [`VLIW_NUM_UNITS],
   input  vliw_pkg::data_t     z_re,
   input  vliw_pkg::data_t     z_im,
   output vliw_pkg::rd_addr_t  rd_addr,
   output vliw_pkg::data_t     operand   [`VLIW_NUM_RD_PORTS]
);
   import vliw_pkg::*;

   localparam entry_t ZRE = entry_t'(`VLIW_Z_RE_ENTRY);
   localparam entry_t ZIM = entry_t'(`VLIW_Z_IM_ENTRY);

   //====================
   // Bank addressing
   //====================
   // Every bank gets the same entry per port, unit field only steers the mux
   always_comb begin
      for (int p = 0; p < `VLIW_NUM_RD_PORTS; p++) begin
         rd_addr[p] = src_addr[p].entry;
      end
   end

   //====================
   // Operand select
   //====================
   always_comb begin
      for (int p = 0; p < `VLIW_NUM_RD_PORTS; p++) begin
         // z entries override the unit field
         if (src_addr[p].entry == ZRE) begin
            operand[p] = z_re;
         end else if (src_addr[p].entry == ZIM) begin
            operand[p] = z_im;
         end else begin
            case (src_addr[p].unit)
               unit_load: operand[p] = bank_data[unit_load][p];
               unit_neg:  operand[p] = bank_data[unit_neg][p];
               unit_add:  operand[p] = bank_data[unit_add][p];
               unit_mul:  operand[p] = bank_data[unit_mul][p];
               default:   operand[p] = '0;
            endcase
         end
      end
   end

endmodule

//--- source/result_bank.sv
//====================
// Result bank
// One unit's 16-entry result array, one write and five read ports
//====================
`timescale 1ns/1ps
`include "vliw_params.svh"

module result_bank (
   input  logic               clk,
   input  logic               reset,
   input  vliw_pkg::wr_req_t  wr_req,
   input  vliw_pkg::rd_addr_t rd_addr,
   output vliw_pkg::rd_data_t rd_data
);
   import vliw_pkg::*;

   data_t mem [`VLIW_NUM_ENTRIES];

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < `VLIW_NUM_ENTRIES; i++) begin
            mem[i] <= '0;
         end
      end else if (wr_req.valid) begin
         mem[wr_req.entry] <= wr_req.data;
      end
   end

   // Read ports see a write from the next cycle on
   always_comb begin
      for (int p = 0; p < `VLIW_NUM_RD_PORTS; p++) begin
         rd_data[p] = mem[rd_addr[p]];
      end
   end

   //====================
   // Checks
   //====================
   // A valid write from the owning unit must carry a known entry
   a_wr_entry_known: assert property (
      @(posedge clk) disable iff (reset)
      wr_req.valid |-> !$isunknown(wr_req.entry)
   ) else $error("bank write with unknown entry");

endmodule

//--- source/vliw_core.sv
//====================
// VLIW core
// Four-slot datapath with per-unit result banks and the z register
//====================
`timescale 1ns/1ps
`include "vliw_params.svh"

module vliw_core (
   input  logic                  clk,
   input  logic                  reset,
   input  vliw_pkg::load_slot_t  load_slot,
   input  vliw_pkg::neg_slot_t   neg_slot,
   input  vliw_pkg::arith_slot_t add_slot,
   input  vliw_pkg::arith_slot_t mul_slot,
   output vliw_pkg::data_t       z_re,
   output vliw_pkg::data_t       z_im
);
   import vliw_pkg::*;

   wr_req_t   wr_req    [`VLIW_NUM_UNITS];
   reg_addr_t src_addr  [`VLIW_NUM_RD_PORTS];
   rd_addr_t  rd_addr;
   rd_data_t  bank_data [`VLIW_NUM_UNITS];
   data_t     operand   [`VLIW_NUM_RD_PORTS];

   // Source addresses in read port order
   assign src_addr[port_neg]  = neg_slot.src;
   assign src_addr[port_add1] = add_slot.src1;
   assign src_addr[port_add2] = add_slot.src2;
   assign src_addr[port_mul1] = mul_slot.src1;
   assign src_addr[port_mul2] = mul_slot.src2;

   //====================
   // Units
   //====================
   exec_units exec_units_inst (
      .clk       (clk),
      .reset     (reset),
      .load_slot (load_slot),
      .neg_slot  (neg_slot),
      .add_slot  (add_slot),
      .mul_slot  (mul_slot),
      .operand   (operand),
      .wr_req    (wr_req)
   );

   // One bank per unit, written only by that unit
   generate
      for (genvar g = 0; g < `VLIW_NUM_UNITS; g++) begin : g_bank
         result_bank result_bank_inst (
            .clk     (clk),
            .reset   (reset),
            .wr_req  (wr_req[g]),
            .rd_addr (rd_addr),
            .rd_data (bank_data[g])
         );
      end
   endgenerate

   operand_router operand_router_inst (
      .src_addr  (src_addr),
      .bank_data (bank_data),
      .z_re      (z_re),
      .z_im      (z_im),
      .rd_addr   (rd_addr),
      .operand   (operand)
   );

   z_register z_register_inst (
      .clk    (clk),
      .reset  (reset),
      .wr_req (wr_req),
      .z_re   (z_re),
      .z_im   (z_im)
   );

endmodule

//--- source/vliw_params.svh
//====================
// VLIW datapath parameters
// Word widths, bank sizes and z register locations
//====================
`ifndef VLIW_PARAMS_SVH
`define VLIW_PARAMS_SVH

// Data and address widths
`define VLIW_DATA_W       27
`define VLIW_ENTRY_W      4

// Bank geometry
`define VLIW_NUM_ENTRIES  16
`define VLIW_NUM_UNITS    4
`define VLIW_NUM_RD_PORTS 5

// z lives at these entries in every bank's address space
`define VLIW_Z_RE_ENTRY   0
`define VLIW_Z_IM_ENTRY   1

`endif

//--- source/vliw_pkg.sv
//====================
// VLIW datapath types
// Units, read ports, instruction slots and write requests
//====================
`include "vliw_params.svh"

package vliw_pkg;

   typedef logic [`VLIW_DATA_W-1:0]  data_t;
   typedef logic [`VLIW_ENTRY_W-1:0] entry_t;

   // Unit that owns a bank, also the z write priority order
   typedef enum logic [1:0] {
      unit_load,
      unit_neg,
      unit_add,
      unit_mul
   } unit_e;

   typedef enum logic [2:0] {
      port_neg,
      port_add1,
      port_add2,
      port_mul1,
      port_mul2
   } rd_port_e;

   typedef struct packed {
      unit_e  unit;
      entry_t entry;
   } reg_addr_t;

   //====================
   // Instruction slots
   //====================
   typedef struct packed {
      logic      enable;
      reg_addr_t dest;
      data_t     value;
   } load_slot_t;

   typedef struct packed {
      logic      enable;
      reg_addr_t src;
      reg_addr_t dest;
   } neg_slot_t;

   // Shared by add and multiply
   typedef struct packed {
      logic      enable;
      reg_addr_t src1;
      reg_addr_t src2;
      reg_addr_t dest;
   } arith_slot_t;

   typedef struct packed {
      logic   valid;
      entry_t entry;
      data_t  data;
   } wr_req_t;

   typedef entry_t [`VLIW_NUM_RD_PORTS-1:0] rd_addr_t;
   typedef data_t  [`VLIW_NUM_RD_PORTS-1:0] rd_data_t;

endpackage

//--- source/z_register.sv
//====================
// z register
// Real and imaginary z with load, negate, add, multiply write priority
//====================
`timescale 1ns/1ps
`include "vliw_params.svh"

module z_register (
   input  logic              clk,
   input  logic              reset,
   input  vliw_pkg::wr_req_t wr_req [`VLIW_NUM_UNITS],
   output vliw_pkg::data_t   z_re,
   output vliw_pkg::data_t   z_im
);
   import vliw_pkg::*;

   localparam int CNT_W = $clog2(`VLIW_NUM_UNITS + 1);

   data_t            z_re_next;
   data_t            z_im_next;
   logic [CNT_W-1:0] re_writers;
   logic [CNT_W-1:0] im_writers;

   // Walk from lowest to highest priority so the load unit wins last
   always_comb begin
      z_re_next  = z_re;
      z_im_next  = z_im;
      re_writers = '0;
      im_writers = '0;
      for (int u = `VLIW_NUM_UNITS - 1; u >= 0; u--) begin
         if (wr_req[u].valid && wr_req[u].entry == entry_t'(`VLIW_Z_RE_ENTRY)) begin
            z_re_next  = wr_req[u].data;
            re_writers = re_writers + 1'b1;
         end
         if (wr_req[u].valid && wr_req[u].entry == entry_t'(`VLIW_Z_IM_ENTRY)) begin
            z_im_next  = wr_req[u].data;
            im_writers = im_writers + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         z_re <= '0;
         z_im <= '0;
      end else begin
         z_re <= z_re_next;
         z_im <= z_im_next;
      end
   end

   // Several units hitting one z part in a cycle, resolved by priority
   c_z_re_collision: cover property (@(posedge clk) disable iff (reset) re_writers > 1);
   c_z_im_collision: cover property (@(posedge clk) disable iff (reset) im_writers > 1);

endmodule

//--- src.f
+incdir+source
source/vliw_pkg.sv
source/exec_units.sv
source/result_bank.sv
source/operand_router.sv
source/z_register.sv
source/vliw_core.sv
sim/vliw_tb.sv
